//--- logic/rv_exmem_config.svh
// rv64i execute and memory subsystem widths

`ifndef RV_EXMEM_CONFIG_SVH
`define RV_EXMEM_CONFIG_SVH

// register file
`define XLEN          64
`define GPR_ADDR_WD   5

// data sram port
`define SRAM_ADDR_WD  32
`define SRAM_DATA_WD  64
`define SRAM_WMASK_WD 8

`endif

//--- logic/rv_exmem_pkg.sv
// rv64i execute and memory subsystem stage packets and operation codes
`default_nettype none

package rv_exmem_pkg;

`include "rv_exmem_config.svh"

  typedef enum logic [3:0] {
    ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU,
    ALU_XOR, ALU_SRL, ALU_SRA, ALU_OR, ALU_AND
  } alu_op_e;

  typedef enum logic {SRC1_RS1, SRC1_PC} src1_sel_e;

  typedef enum logic [1:0] {SRC2_RS2, SRC2_IMM, SRC2_FOUR} src2_sel_e;

  // same encoding as load/store funct3
  typedef enum logic [2:0] {
    MEM_B  = 3'b000,
    MEM_H  = 3'b001,
    MEM_W  = 3'b010,
    MEM_D  = 3'b011,
    MEM_BU = 3'b100,
    MEM_HU = 3'b101,
    MEM_WU = 3'b110
  } mem_op_e;

  typedef struct packed {
    logic [`XLEN-1:0]        rs1data;
    logic [`XLEN-1:0]        rs2data;
    logic [`XLEN-1:0]        imm;
    logic [`XLEN-1:0]        pc;
    src1_sel_e               src1_sel;
    src2_sel_e               src2_sel;
    alu_op_e                 alu_op;
    logic                    word_cut;   // *w instructions
    logic [`GPR_ADDR_WD-1:0] rd;
    logic                    gpr_wen;
    logic                    mem_ren;
    logic                    mem_wen;
    mem_op_e                 mem_op;
  } ds_to_es_t;

  typedef struct packed {
    logic [`GPR_ADDR_WD-1:0] rd;
    logic                    gpr_wen;
    logic                    mem_ren;
    mem_op_e                 mem_op;
    logic [`XLEN-1:0]        alu_result;
    logic [2:0]              addr_low;   // byte offset in the dword
  } es_to_ms_t;

  typedef struct packed {
    logic [`GPR_ADDR_WD-1:0] rd;
    logic                    gpr_wen;
    logic [`XLEN-1:0]        result;
  } ms_to_ws_t;

  typedef struct packed {
    logic [`GPR_ADDR_WD-1:0] rd;
    logic                    valid;
    logic [`XLEN-1:0]        data;
  } bypass_t;

endpackage

`default_nettype wire

//--- logic/rv_alu.sv
// rv64i integer alu with operand select and 32-bit word truncation
`timescale 1ns/1ns
`default_nettype none

`include "rv_exmem_config.svh"

module rv_alu (
  input  wire logic [`XLEN-1:0]         i_rs1data,
  input  wire logic [`XLEN-1:0]         i_rs2data,
  input  wire logic [`XLEN-1:0]         i_imm,
  input  wire logic [`XLEN-1:0]         i_pc,
  input  wire rv_exmem_pkg::src1_sel_e  i_src1_sel,
  input  wire rv_exmem_pkg::src2_sel_e  i_src2_sel,
  input  wire rv_exmem_pkg::alu_op_e    i_alu_op,
  input  wire logic                     i_word_cut,
  output logic [`XLEN-1:0]              o_result
);

  localparam int HALF = `XLEN / 2;

  logic [`XLEN-1:0] src1;
  logic [`XLEN-1:0] src2;
  logic [`XLEN-1:0] sh_src;
  logic [5:0]       shamt;
  logic [`XLEN-1:0] raw;

  // operand select
  always_comb begin
    src1 = (i_src1_sel == rv_exmem_pkg::SRC1_PC) ? i_pc : i_rs1data;
    case (i_src2_sel)
      rv_exmem_pkg::SRC2_IMM:  src2 = i_imm;
      rv_exmem_pkg::SRC2_FOUR: src2 = 'd4;   // link address
      default:                 src2 = i_rs2data;
    endcase
  end

  // word shifts only see the low half of rs1
  always_comb begin
    shamt  = i_word_cut ? {1'b0, src2[4:0]} : src2[5:0];
    sh_src = src1;
    if (i_word_cut) begin
      if (i_alu_op == rv_exmem_pkg::ALU_SRA) begin
        sh_src = {{HALF{src1[HALF-1]}}, src1[HALF-1:0]};
      end else begin
        sh_src = {{HALF{1'b0}}, src1[HALF-1:0]};
      end
    end
  end

  always_comb begin
    case (i_alu_op)
      rv_exmem_pkg::ALU_ADD:  raw = src1 + src2;
      rv_exmem_pkg::ALU_SUB:  raw = src1 - src2;
      rv_exmem_pkg::ALU_SLL:  raw = sh_src << shamt;
      rv_exmem_pkg::ALU_SLT:  raw = {{(`XLEN-1){1'b0}}, $signed(src1) < $signed(src2)};
      rv_exmem_pkg::ALU_SLTU: raw = {{(`XLEN-1){1'b0}}, src1 < src2};
      rv_exmem_pkg::ALU_XOR:  raw = src1 ^ src2;
      rv_exmem_pkg::ALU_SRL:  raw = sh_src >> shamt;
      rv_exmem_pkg::ALU_SRA:  raw = $signed(sh_src) >>> shamt;
      rv_exmem_pkg::ALU_OR:   raw = src1 | src2;
      rv_exmem_pkg::ALU_AND:  raw = src1 & src2;
      default:                raw = '0;
    endcase
  end

  // sign-extend low word for *w ops
  assign o_result = i_word_cut ? {{HALF{raw[HALF-1]}}, raw[HALF-1:0]} : raw;

endmodule

`default_nettype wire

//--- logic/rv_store_align.sv
// store byte lane replication and byte enable generation
`timescale 1ns/1ns
`default_nettype none

`include "rv_exmem_config.svh"

module rv_store_align (
  input  wire rv_exmem_pkg::mem_op_e  i_mem_op,
  input  wire logic [2:0]             i_addr_low,
  input  wire logic [`XLEN-1:0]       i_wdata,
  output logic [`SRAM_WMASK_WD-1:0]   o_wmask,
  output logic [`SRAM_DATA_WD-1:0]    o_wdata
);

  // funct3[1:0] gives the access size
  always_comb begin
    case (i_mem_op[1:0])
      2'b00: begin
        o_wdata = {8{i_wdata[7:0]}};
        o_wmask = 8'h01 << i_addr_low;
      end
      2'b01: begin
        o_wdata = {4{i_wdata[15:0]}};
        o_wmask = 8'h03 << {i_addr_low[2:1], 1'b0};   // halfword aligned
      end
      2'b10: begin
        o_wdata = {2{i_wdata[31:0]}};
        o_wmask = 8'h0f << {i_addr_low[2], 2'b00};
      end
      default: begin
        o_wdata = i_wdata;
        o_wmask = 8'hff;
      end
    endcase
  end

endmodule

`default_nettype wire

//--- logic/rv_ex_stage.sv
// execute stage with alu, data sram request and decode feedback
`timescale 1ns/1ns
`default_nettype none

`include "rv_exmem_config.svh"

module rv_ex_stage (
  input  wire logic                       i_clk,
  input  wire logic                       i_rst_n,
  // from decode
  input  wire logic                       i_ds_to_es_valid,
  input  wire rv_exmem_pkg::ds_to_es_t    i_ds_to_es_bus,
  output logic                            o_es_allowin,
  // to memory stage
  input  wire logic                       i_ms_allowin,
  output logic                            o_es_to_ms_valid,
  output rv_exmem_pkg::es_to_ms_t         o_es_to_ms_bus,
  // data sram request
  output logic                            o_data_sram_ren,
  output logic                            o_data_sram_wen,
  output logic [`SRAM_ADDR_WD-1:0]        o_data_sram_addr,
  output logic [`SRAM_WMASK_WD-1:0]       o_data_sram_wmask,
  output logic [`SRAM_DATA_WD-1:0]        o_data_sram_wdata,
  input  wire logic                       i_data_sram_addr_ok,
  // back to decode
  output rv_exmem_pkg::bypass_t           o_es_bypass,
  output logic                            o_es_load_stall
);

  logic                    es_valid;
  logic                    es_ready_go;
  logic                    es_mem_access;
  rv_exmem_pkg::ds_to_es_t es_bus;
  logic [`XLEN-1:0]        es_alu_result;

  assign es_mem_access    = es_bus.mem_ren | es_bus.mem_wen;
  assign es_ready_go      = es_mem_access ? i_data_sram_addr_ok : 1'b1;   // wait addr accept
  assign o_es_allowin     = !es_valid || (es_ready_go && i_ms_allowin);
  assign o_es_to_ms_valid = es_valid && es_ready_go;

  always_ff @(posedge i_clk) begin
    if (!i_rst_n) begin
      es_valid <= 1'b0;
    end else if (o_es_allowin) begin
      es_valid <= i_ds_to_es_valid;
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_ds_to_es_valid && o_es_allowin) begin
      es_bus <= i_ds_to_es_bus;
    end
  end

  rv_alu u_alu (
    .i_rs1data  (es_bus.rs1data),
    .i_rs2data  (es_bus.rs2data),
    .i_imm      (es_bus.imm),
    .i_pc       (es_bus.pc),
    .i_src1_sel (es_bus.src1_sel),
    .i_src2_sel (es_bus.src2_sel),
    .i_alu_op   (es_bus.alu_op),
    .i_word_cut (es_bus.word_cut),
    .o_result   (es_alu_result)
  );

  rv_store_align u_store_align (
    .i_mem_op   (es_bus.mem_op),
    .i_addr_low (es_alu_result[2:0]),
    .i_wdata    (es_bus.rs2data),
    .o_wmask    (o_data_sram_wmask),
    .o_wdata    (o_data_sram_wdata)
  );

  // a read only goes out when the load can move on to mem
  assign o_data_sram_ren  = es_valid && es_bus.mem_ren && i_ms_allowin;
  assign o_data_sram_wen  = es_valid && es_bus.mem_wen;
  assign o_data_sram_addr = es_alu_result[`SRAM_ADDR_WD-1:0];   // rs1 + imm

  assign o_es_to_ms_bus.rd         = es_bus.rd;
  assign o_es_to_ms_bus.gpr_wen    = es_bus.gpr_wen;
  assign o_es_to_ms_bus.mem_ren    = es_bus.mem_ren;
  assign o_es_to_ms_bus.mem_op     = es_bus.mem_op;
  assign o_es_to_ms_bus.alu_result = es_alu_result;
  assign o_es_to_ms_bus.addr_low   = es_alu_result[2:0];

  assign o_es_load_stall = es_valid && es_bus.mem_ren;

  // load result is not known here, decode stalls on it instead
  always_comb begin
    o_es_bypass = '0;
    if (es_valid && es_bus.gpr_wen && !es_bus.mem_ren) begin
      o_es_bypass.rd    = es_bus.rd;
      o_es_bypass.valid = 1'b1;
      o_es_bypass.data  = es_alu_result;
    end
  end

endmodule

`default_nettype wire

//--- logic/rv_mem_stage.sv
// memory stage waiting on load data, with load alignment and extension
`timescale 1ns/1ns
`default_nettype none

`include "rv_exmem_config.svh"

module rv_mem_stage (
  input  wire logic                       i_clk,
  input  wire logic                       i_rst_n,
  // from execute
  input  wire logic                       i_es_to_ms_valid,
  input  wire rv_exmem_pkg::es_to_ms_t    i_es_to_ms_bus,
  output logic                            o_ms_allowin,
  // to writeback
  input  wire logic                       i_ws_allowin,
  output logic                            o_ms_to_ws_valid,
  output rv_exmem_pkg::ms_to_ws_t         o_ms_to_ws_bus,
  // load data return
  input  wire logic                       i_data_sram_data_ok,
  input  wire logic [`SRAM_DATA_WD-1:0]   i_data_sram_rdata,
  // back to decode
  output rv_exmem_pkg::bypass_t           o_ms_bypass
);

  logic                    ms_valid;
  logic                    ms_ready_go;
  logic                    data_got;
  logic [`XLEN-1:0]        rdata_r;
  logic [`XLEN-1:0]        shifted;
  logic [`XLEN-1:0]        load_val;
  logic [`XLEN-1:0]        ms_result;
  rv_exmem_pkg::es_to_ms_t ms_bus;

  assign ms_ready_go      = !ms_bus.mem_ren || data_got;
  assign o_ms_allowin     = !ms_valid || (ms_ready_go && i_ws_allowin);
  assign o_ms_to_ws_valid = ms_valid && ms_ready_go;

  always_ff @(posedge i_clk) begin
    if (!i_rst_n) begin
      ms_valid <= 1'b0;
      data_got <= 1'b0;
    end else begin
      if (o_ms_allowin) begin
        ms_valid <= i_es_to_ms_valid;
      end
      if (i_es_to_ms_valid && o_ms_allowin) begin
        data_got <= 1'b0;   // new entry
      end else if (ms_valid && ms_bus.mem_ren && i_data_sram_data_ok) begin
        data_got <= 1'b1;
      end
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_es_to_ms_valid && o_ms_allowin) begin
      ms_bus <= i_es_to_ms_bus;
    end
    if (ms_valid && !data_got && i_data_sram_data_ok) begin
      rdata_r <= i_data_sram_rdata;
    end
  end

  // pick addressed bytes then extend
  always_comb begin
    shifted = rdata_r >> {ms_bus.addr_low, 3'b000};
    case (ms_bus.mem_op)
      rv_exmem_pkg::MEM_B:  load_val = {{(`XLEN-8){shifted[7]}}, shifted[7:0]};
      rv_exmem_pkg::MEM_H:  load_val = {{(`XLEN-16){shifted[15]}}, shifted[15:0]};
      rv_exmem_pkg::MEM_W:  load_val = {{(`XLEN-32){shifted[31]}}, shifted[31:0]};
      rv_exmem_pkg::MEM_BU: load_val = {{(`XLEN-8){1'b0}}, shifted[7:0]};
      rv_exmem_pkg::MEM_HU: load_val = {{(`XLEN-16){1'b0}}, shifted[15:0]};
      rv_exmem_pkg::MEM_WU: load_val = {{(`XLEN-32){1'b0}}, shifted[31:0]};
      default:              load_val = shifted;   // ld
    endcase
  end

  assign ms_result = ms_bus.mem_ren ? load_val : ms_bus.alu_result;

  assign o_ms_to_ws_bus.rd      = ms_bus.rd;
  assign o_ms_to_ws_bus.gpr_wen = ms_bus.gpr_wen;
  assign o_ms_to_ws_bus.result  = ms_result;

  // loads forward only after data is back
  always_comb begin
    o_ms_bypass = '0;
    if (ms_valid && ms_bus.gpr_wen && ms_ready_go) begin
      o_ms_bypass.rd    = ms_bus.rd;
      o_ms_bypass.valid = 1'b1;
      o_ms_bypass.data  = ms_result;
    end
  end

endmodule

`default_nettype wire

//--- logic/rv_exmem_top.sv
// execute and memory stages of the rv64i pipeline
`timescale 1ns/1ns
`default_nettype none

`include "rv_exmem_config.svh"

module rv_exmem_top (
  input  wire logic                       i_clk,
  input  wire logic                       i_rst_n,
  input  wire logic                       i_ds_to_es_valid,
  input  wire rv_exmem_pkg::ds_to_es_t    i_ds_to_es_bus,
  output logic                            o_es_allowin,
  input  wire logic                       i_ws_allowin,
  output logic                            o_ms_to_ws_valid,
  output rv_exmem_pkg::ms_to_ws_t         o_ms_to_ws_bus,
  output logic                            o_data_sram_ren,
  output logic                            o_data_sram_wen,
  output logic [`SRAM_ADDR_WD-1:0]        o_data_sram_addr,
  output logic [`SRAM_WMASK_WD-1:0]       o_data_sram_wmask,
  output logic [`SRAM_DATA_WD-1:0]        o_data_sram_wdata,
  input  wire logic                       i_data_sram_addr_ok,
  input  wire logic                       i_data_sram_data_ok,
  input  wire logic [`SRAM_DATA_WD-1:0]   i_data_sram_rdata,
  output rv_exmem_pkg::bypass_t           o_es_bypass,
  output rv_exmem_pkg::bypass_t           o_ms_bypass,
  output logic                            o_es_load_stall
);

  logic                    es_to_ms_valid;
  logic                    ms_allowin;
  rv_exmem_pkg::es_to_ms_t es_to_ms_bus;

  rv_ex_stage u_ex_stage (
    .i_clk               (i_clk),
    .i_rst_n             (i_rst_n),
    .i_ds_to_es_valid    (i_ds_to_es_valid),
    .i_ds_to_es_bus      (i_ds_to_es_bus),
    .o_es_allowin        (o_es_allowin),
    .i_ms_allowin        (ms_allowin),
    .o_es_to_ms_valid    (es_to_ms_valid),
    .o_es_to_ms_bus      (es_to_ms_bus),
    .o_data_sram_ren     (o_data_sram_ren),
    .o_data_sram_wen     (o_data_sram_wen),
    .o_data_sram_addr    (o_data_sram_addr),
    .o_data_sram_wmask   (o_data_sram_wmask),
    .o_data_sram_wdata   (o_data_sram_wdata),
    .i_data_sram_addr_ok (i_data_sram_addr_ok),
    .o_es_bypass         (o_es_bypass),
    .o_es_load_stall     (o_es_load_stall)
  );

  rv_mem_stage u_mem_stage (
    .i_clk               (i_clk),
    .i_rst_n             (i_rst_n),
    .i_es_to_ms_valid    (es_to_ms_valid),
    .i_es_to_ms_bus      (es_to_ms_bus),
    .o_ms_allowin        (ms_allowin),
    .i_ws_allowin        (i_ws_allowin),
    .o_ms_to_ws_valid    (o_ms_to_ws_valid),
    .o_ms_to_ws_bus      (o_ms_to_ws_bus),
    .i_data_sram_data_ok (i_data_sram_data_ok),
    .i_data_sram_rdata   (i_data_sram_rdata),
    .o_ms_bypass         (o_ms_bypass)
  );

endmodule

`default_nettype wire

//--- verification/rv_exmem_sva.sv
// handshake hold and reset assertions for the execute and memory subsystem
`timescale 1ns/1ns
`default_nettype none

module rv_exmem_sva (
  input wire logic                    i_clk,
  input wire logic                    i_rst_n,
  input wire logic                    i_ws_allowin,
  input wire logic                    i_ms_to_ws_valid,
  input wire rv_exmem_pkg::ms_to_ws_t i_ms_to_ws_bus,
  input wire logic                    i_ms_allowin,
  input wire logic                    i_es_to_ms_valid,
  input wire rv_exmem_pkg::es_to_ms_t i_es_to_ms_bus,
  input wire logic                    i_sram_ren,
  input wire logic                    i_sram_wen,
  input wire logic                    i_load_stall,
  input wire rv_exmem_pkg::bypass_t   i_es_bypass,
  input wire rv_exmem_pkg::bypass_t   i_ms_bypass
);

  int fail_count = 0;   // read by the testbench at the end

  // everything quiet in the cycle after a reset edge
  a_reset_clear: assert property (@(posedge i_clk)
    !i_rst_n |=> !(i_ms_to_ws_valid || i_es_to_ms_valid || i_sram_ren || i_sram_wen
                   || i_load_stall || i_es_bypass.valid || i_ms_bypass.valid))
    else begin
      fail_count++;
      $error("valid or enable high after reset");
    end

  a_ms_hold: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    i_ms_to_ws_valid && !i_ws_allowin |=> i_ms_to_ws_valid && $stable(i_ms_to_ws_bus))
    else begin
      fail_count++;
      $error("writeback packet changed while held");
    end

  a_es_hold: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    i_es_to_ms_valid && !i_ms_allowin |=> $stable(i_es_to_ms_bus))
    else begin
      fail_count++;
      $error("execute packet changed while held");
    end

endmodule

`default_nettype wire

//--- verification/rv_exmem_tb.sv
// testbench for the rv64i execute and memory stages with a data sram model
`timescale 1ns/1ns
`default_nettype none

`include "rv_exmem_config.svh"

module rv_exmem_tb;

  localparam int NUM_INSTR = 600;
  localparam int TIMEOUT   = 200;   // cycles without a writeback

  typedef struct packed {
    logic [`SRAM_ADDR_WD-1:0]  addr;
    logic [`SRAM_WMASK_WD-1:0] mask;
    logic [`SRAM_DATA_WD-1:0]  data;   // value already in its byte lanes
  } store_t;

  logic                          clk;
  logic                          rst_n;
  logic                          ds_valid;
  rv_exmem_pkg::ds_to_es_t       ds_bus;
  logic                          es_allowin;
  logic                          ws_allowin;
  logic                          ms_valid;
  rv_exmem_pkg::ms_to_ws_t       ms_bus;
  logic                          sram_ren;
  logic                          sram_wen;
  logic [`SRAM_ADDR_WD-1:0]      sram_addr;
  logic [`SRAM_WMASK_WD-1:0]     sram_wmask;
  logic [`SRAM_DATA_WD-1:0]      sram_wdata;
  logic                          addr_ok;
  logic                          data_ok;
  logic [`SRAM_DATA_WD-1:0]      sram_rdata;
  rv_exmem_pkg::bypass_t         es_bypass;
  rv_exmem_pkg::bypass_t         ms_bypass;
  logic                          load_stall;

  logic [31:0]                   lfsr_state = 32'h21f;
  logic [63:0]                   mem [logic [29:0]];   // msb picks sram or reference copy
  store_t                        exp_st[$];
  rv_exmem_pkg::ms_to_ws_t       exp_wb[$];
  rv_exmem_pkg::ds_to_es_t       es_pkt;
  logic                          es_occ = 1'b0;
  logic [63:0]                   rd_word;
  int                            rd_wait = 0;
  int                            issued = 0;
  int                            retired = 0;
  int                            idle = 0;
  int                            checks = 0;
  int                            value_errors = 0;
  int                            other_errors = 0;

  rv_exmem_top dut (
    .i_clk               (clk),
    .i_rst_n             (rst_n),
    .i_ds_to_es_valid    (ds_valid),
    .i_ds_to_es_bus      (ds_bus),
    .o_es_allowin        (es_allowin),
    .i_ws_allowin        (ws_allowin),
    .o_ms_to_ws_valid    (ms_valid),
    .o_ms_to_ws_bus      (ms_bus),
    .o_data_sram_ren     (sram_ren),
    .o_data_sram_wen     (sram_wen),
    .o_data_sram_addr    (sram_addr),
    .o_data_sram_wmask   (sram_wmask),
    .o_data_sram_wdata   (sram_wdata),
    .i_data_sram_addr_ok (addr_ok),
    .i_data_sram_data_ok (data_ok),
    .i_data_sram_rdata   (sram_rdata),
    .o_es_bypass         (es_bypass),
    .o_ms_bypass         (ms_bypass),
    .o_es_load_stall     (load_stall)
  );

  bind rv_exmem_top rv_exmem_sva u_sva (
    .i_clk            (i_clk),
    .i_rst_n          (i_rst_n),
    .i_ws_allowin     (i_ws_allowin),
    .i_ms_to_ws_valid (o_ms_to_ws_valid),
    .i_ms_to_ws_bus   (o_ms_to_ws_bus),
    .i_ms_allowin     (ms_allowin),
    .i_es_to_ms_valid (es_to_ms_valid),
    .i_es_to_ms_bus   (es_to_ms_bus),
    .i_sram_ren       (o_data_sram_ren),
    .i_sram_wen       (o_data_sram_wen),
    .i_load_stall     (o_es_load_stall),
    .i_es_bypass      (o_es_bypass),
    .i_ms_bypass      (o_ms_bypass)
  );

  // x^32 + x^22 + x^2 + x + 1, right shifting
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  function logic [63:0] rand_bits(input int n);
    logic [63:0] v;
    int          i;
    v = '0;
    for (i = 0; i < n; i++) begin
      v = {v[62:0], lfsr_state[0]};
      lfsr_state = lfsr_step(lfsr_state);
    end
    return v;
  endfunction

  function automatic logic [63:0] lane_mask(input logic [7:0] m);
    logic [63:0] r;
    int          i;
    for (i = 0; i < 8; i++) begin
      r[8*i +: 8] = {8{m[i]}};
    end
    return r;
  endfunction

  function automatic logic [63:0] mem_read(input logic which, input logic [31:0] addr);
    logic [29:0] key;
    key = {which, addr[31:3]};
    if (mem.exists(key)) begin
      return mem[key];
    end
    return {addr[31:3], 3'b000, ~addr[31:3], 3'b101} ^ 64'h9e37_79b9_7f4a_7c15;   // unwritten fill
  endfunction

  task automatic mem_write(input logic which, input logic [31:0] addr, input logic [7:0] m,
                           input logic [63:0] data);
    logic [63:0] lm;
    lm = lane_mask(m);
    mem[{which, addr[31:3]}] = (mem_read(which, addr) & ~lm) | (data & lm);
  endtask

  // rv64i rules; word ops shift by 5 bits and keep the sign of bit 31
  function automatic logic [63:0] alu_model(input rv_exmem_pkg::ds_to_es_t p);
    logic [63:0] a;
    logic [63:0] b;
    logic [63:0] r;
    logic [31:0] w;
    a = (p.src1_sel == rv_exmem_pkg::SRC1_PC) ? p.pc : p.rs1data;
    case (p.src2_sel)
      rv_exmem_pkg::SRC2_IMM:  b = p.imm;
      rv_exmem_pkg::SRC2_FOUR: b = 64'd4;
      default:                 b = p.rs2data;
    endcase
    case (p.alu_op)
      rv_exmem_pkg::ALU_ADD:  r = a + b;
      rv_exmem_pkg::ALU_SUB:  r = a - b;
      rv_exmem_pkg::ALU_SLT:  r = {63'd0, $signed(a) < $signed(b)};
      rv_exmem_pkg::ALU_SLTU: r = {63'd0, a < b};
      rv_exmem_pkg::ALU_XOR:  r = a ^ b;
      rv_exmem_pkg::ALU_OR:   r = a | b;
      rv_exmem_pkg::ALU_AND:  r = a & b;
      default: begin
        if (p.alu_op == rv_exmem_pkg::ALU_SLL) begin
          w = a[31:0] << b[4:0];
          r = a << b[5:0];
        end else if (p.alu_op == rv_exmem_pkg::ALU_SRL) begin
          w = a[31:0] >> b[4:0];
          r = a >> b[5:0];
        end else begin
          w = $signed(a[31:0]) >>> b[4:0];
          r = $signed(a) >>> b[5:0];
        end
        if (p.word_cut) r = {32'd0, w};
      end
    endcase
    if (p.word_cut) r = {{32{r[31]}}, r[31:0]};
    return r;
  endfunction

  function automatic logic [63:0] extend(input logic [63:0] v, input int bytes, input logic sgn);
    logic [63:0] keep;
    logic [63:0] r;
    keep = {64{1'b1}} >> (64 - 8 * bytes);
    r = v & keep;
    if (sgn && v[8*bytes-1]) r = r | ~keep;
    return r;
  endfunction

  function rv_exmem_pkg::ds_to_es_t build_packet();
    rv_exmem_pkg::ds_to_es_t p;
    logic [63:0]             t;
    logic [2:0]              op;
    logic [2:0]              low;
    p = '0;
    t = rand_bits(2);
    p.rd      = rand_bits(5);
    p.rs1data = rand_bits(64);
    p.rs2data = rand_bits(64);
    p.pc      = rand_bits(64);
    p.imm     = rand_bits(12);
    p.imm     = {{52{p.imm[11]}}, p.imm[11:0]};
    p.gpr_wen = rand_bits(3) != 0;
    if (t[1] == 1'b0) begin
      p.src1_sel = rv_exmem_pkg::src1_sel_e'(rand_bits(1));
      t = rand_bits(2);
      p.src2_sel = rv_exmem_pkg::src2_sel_e'((t == 3) ? 1 : t);
      p.alu_op   = rv_exmem_pkg::alu_op_e'(rand_bits(4) % 10);
      p.word_cut = rand_bits(1);
    end else begin
      op  = rand_bits(3);
      if (t[0]) op[2] = 1'b0;   // stores have no unsigned forms
      if (op == 3'b111) op = 3'b011;
      low = 3'b111 << op[1:0];
      low = low & rand_bits(3);
      p.rs1data  = 64'h1000 + (rand_bits(4) << 3);   // small window so loads hit stores
      p.imm      = {61'd0, low};
      p.src1_sel = rv_exmem_pkg::SRC1_RS1;
      p.src2_sel = rv_exmem_pkg::SRC2_IMM;
      p.alu_op   = rv_exmem_pkg::ALU_ADD;
      p.mem_op   = rv_exmem_pkg::mem_op_e'(op);
      p.mem_ren  = !t[0];
      p.mem_wen  = t[0];
      if (t[0]) p.gpr_wen = 1'b0;
      else p.gpr_wen = 1'b1;
    end
    return p;
  endfunction

  task automatic check_value(input string name, input logic [127:0] exp, input logic [127:0] act);
    checks++;
    assert (act === exp) else begin
      value_errors++;
      $display("CHECK FAILED %s expected %0h actual %0h", name, exp, act);
    end
  endtask

  // expected writeback and store for an accepted packet, in issue order
  task automatic record_issue(input rv_exmem_pkg::ds_to_es_t p);
    rv_exmem_pkg::ms_to_ws_t wb;
    store_t                  st;
    logic [63:0]             addr;
    int                      bytes;
    addr  = alu_model(p);
    bytes = 1 << p.mem_op[1:0];
    wb.rd      = p.rd;
    wb.gpr_wen = p.gpr_wen;
    wb.result  = addr;
    if (p.mem_ren) begin
      wb.result = extend(mem_read(1'b1, addr) >> (8 * addr[2:0]), bytes, !p.mem_op[2]);
    end
    if (p.mem_wen) begin
      st.addr = addr[31:0];
      st.mask = ((9'h1 << bytes) - 9'h1) << addr[2:0];
      st.data = p.rs2data << (8 * addr[2:0]);
      exp_st.push_back(st);
      mem_write(1'b1, st.addr, st.mask, st.data);
    end
    exp_wb.push_back(wb);
    issued++;
  endtask

  task automatic sample_and_check();
    rv_exmem_pkg::bypass_t   bp;
    rv_exmem_pkg::ms_to_ws_t front;
    store_t                  st;
    bp = '0;
    if (es_occ && es_pkt.gpr_wen && !es_pkt.mem_ren) begin
      bp.rd    = es_pkt.rd;
      bp.valid = 1'b1;
      bp.data  = alu_model(es_pkt);
    end
    check_value("es_bypass", bp, es_bypass);
    check_value("es_load_stall", es_occ && es_pkt.mem_ren, load_stall);
    check_value("sram_wen", es_occ && es_pkt.mem_wen, sram_wen);
    if (sram_wen) begin
      if (exp_st.size() == 0) begin
        other_errors++;
        $display("store request seen with no store in execute");
      end else begin
        st = exp_st[0];
        check_value("store_addr", st.addr, sram_addr);
        check_value("store_mask", st.mask, sram_wmask);
        check_value("store_data", st.data & lane_mask(st.mask), sram_wdata & lane_mask(st.mask));
        if (addr_ok) begin
          mem_write(1'b0, sram_addr, sram_wmask, sram_wdata);
          if (es_allowin) void'(exp_st.pop_front());
        end
      end
    end
    if (sram_ren && !(es_occ && es_pkt.mem_ren)) begin
      other_errors++;
      $display("read request seen with no load in execute");
    end
    if (sram_ren && addr_ok && !es_allowin) begin
      other_errors++;
      $display("read accepted while the load could not leave execute");
    end
    if (sram_ren && addr_ok) begin
      rd_word = mem_read(1'b0, sram_addr);
      rd_wait = 1 + rand_bits(2) % 3;
    end
    bp = '0;
    if (ms_valid && exp_wb.size() != 0 && exp_wb[0].gpr_wen) begin
      bp.rd    = exp_wb[0].rd;
      bp.valid = 1'b1;
      bp.data  = exp_wb[0].result;
    end
    check_value("ms_bypass", bp, ms_bypass);
    idle++;
    if (ms_valid && ws_allowin) begin
      if (exp_wb.size() == 0) begin
        other_errors++;
        $display("writeback seen with no instruction in flight");
      end else begin
        front = exp_wb.pop_front();
        check_value("wb_gpr_wen", front.gpr_wen, ms_bus.gpr_wen);
        check_value("wb_rd", front.rd, ms_bus.rd);
        if (front.gpr_wen) check_value("wb_result", front.result, ms_bus.result);
      end
      retired++;
      idle = 0;
    end
    if (ds_valid && es_allowin) record_issue(ds_bus);
    if (es_allowin) begin
      es_occ = ds_valid;
      es_pkt = ds_bus;
    end
  endtask

  task automatic drive_next();
    ws_allowin = rand_bits(2) != 0;
    addr_ok    = rand_bits(1);
    data_ok    = 1'b0;
    sram_rdata = '0;
    if (rd_wait > 0) begin
      rd_wait--;
      if (rd_wait == 0) begin
        data_ok    = 1'b1;
        sram_rdata = rd_word;
      end
    end
    // hold an unaccepted packet, otherwise maybe send the next one
    if (!ds_valid) begin
      if (issued < NUM_INSTR && rand_bits(2) != 0) begin
        ds_valid = 1'b1;
        ds_bus   = build_packet();
      end else begin
        ds_valid = 1'b0;
      end
    end
  endtask

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  initial begin
    logic taken;
    rst_n      = 1'b0;
    ds_valid   = 1'b0;
    ds_bus     = '0;
    ws_allowin = 1'b0;
    addr_ok    = 1'b0;
    data_ok    = 1'b0;
    sram_rdata = '0;
    repeat (5) @(posedge clk);
    #2;
    rst_n = 1'b1;
    while (retired < NUM_INSTR && idle < TIMEOUT) begin
      @(negedge clk);
      taken = ds_valid && es_allowin;
      sample_and_check();
      @(posedge clk);
      #2;
      if (taken) ds_valid = 1'b0;
      drive_next();
    end
    if (idle >= TIMEOUT) begin
      other_errors++;
      $display("timeout: no writeback for %0d cycles, %0d of %0d retired",
               TIMEOUT, retired, NUM_INSTR);
    end
    if (exp_st.size() != 0) begin
      other_errors++;
      $display("%0d expected stores never reached the sram", exp_st.size());
    end
    $display("checks %0d, value errors %0d, other errors %0d, assertion errors %0d",
             checks, value_errors, other_errors, dut.u_sva.fail_count);
    if (value_errors == 0 && other_errors == 0 && dut.u_sva.fail_count == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- filelist.f
+incdir+logic
logic/rv_exmem_pkg.sv
logic/rv_alu.sv
logic/rv_store_align.sv
logic/rv_ex_stage.sv
logic/rv_mem_stage.sv
logic/rv_exmem_top.sv
verification/rv_exmem_sva.sv
verification/rv_exmem_tb.sv
